//--- source/f2c_pkg.sv
package f2c_pkg;

  // Ring geometry and burst limits
  localparam int ring_awidth = 6;
  localparam int beat_bytes = 8;
  localparam int max_burst = 8;

  typedef logic [31:0] addr_t;

  // One packet beat as it leaves the packet stream
  typedef struct packed {
    logic [63:0] data;
    logic        sop;
    logic        eop;
  } beat_t;

  // Per-packet record with the host queue state of both rings
  typedef struct packed {
    addr_t                  pkt_base;
    logic [ring_awidth-1:0] pkt_tail;
    addr_t                  dsc_base;
    logic [ring_awidth-1:0] dsc_tail;
    logic [7:0]             queue_id;
    logic [6:0]             size;
    logic                   drop;
    logic                   needs_dsc;
  } pkt_meta_t;

  // Transmit completion notice
  typedef struct packed {
    addr_t       dsc_addr;
    addr_t       transfer_addr;
    logic [15:0] length;
  } tx_compl_t;

  // Descriptor word, the top bit tells the host which view applies
  typedef union packed {
    struct packed {
      logic        signal;
      logic [15:0] tail;
      logic [7:0]  queue_id;
      logic [38:0] pad;
    } rx_view;
    struct packed {
      logic        signal;
      addr_t       transfer_addr;
      logic [15:0] length;
      logic [14:0] pad;
    } compl_view;
  } dsc_word_u;

endpackage

//--- source/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo #(
  parameter int width = 8,
  parameter int depth = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [width-1:0]          in_data,
  input  logic                      in_valid,
  output logic                      in_ready,
  output logic [width-1:0]          out_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [$clog2(depth):0]    occupancy
);

  localparam int aw = $clog2(depth);

  logic [width-1:0] mem [depth];
  logic [aw-1:0]    wr_ptr;
  logic [aw-1:0]    rd_ptr;
  logic [aw:0]      buf_count;

  logic push;
  logic load;
  logic buf_empty;
  logic bypass;
  logic wr_en;
  logic rd_en;

  // Output register takes a new entry when it is empty or being drained
  assign load      = !out_valid || out_ready;
  assign push      = in_valid && in_ready;
  assign buf_empty = (buf_count == '0);
  // Straight into the output register when nothing is queued ahead
  assign bypass    = push && buf_empty && load;
  assign wr_en     = push && !bypass;
  assign rd_en     = load && !buf_empty;

  assign occupancy = buf_count + {{aw{1'b0}}, out_valid};
  assign in_ready  = (occupancy < (aw + 1)'(depth));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      buf_count <= '0;
      out_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      buf_count <= buf_count + (aw + 1)'(wr_en) - (aw + 1)'(rd_en);
      if (load) begin
        out_valid <= !buf_empty || push;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
    if (load) begin
      out_data <= buf_empty ? in_data : mem[rd_ptr];
    end
  end

endmodule

//--- source/dma_write_engine.sv
`timescale 1ns/10ps

module dma_write_engine (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         sw_reset,
  input  logic [f2c_pkg::ring_awidth:0] pkt_ring_size,
  input  logic [f2c_pkg::ring_awidth:0] dsc_ring_size,
  input  f2c_pkg::beat_t               beat_data,
  input  logic                         beat_valid,
  output logic                         beat_ready,
  input  f2c_pkg::pkt_meta_t           meta_data,
  input  logic                         meta_valid,
  output logic                         meta_ready,
  input  f2c_pkg::tx_compl_t           compl_data,
  input  logic                         compl_valid,
  output logic                         compl_ready,
  input  logic                         mem_waitrequest,
  output logic                         req_write,
  output f2c_pkg::addr_t               req_address,
  output logic [63:0]                  req_writedata,
  output logic [3:0]                   req_burstcount
);

  localparam logic [1:0] st_idle           = 2'd0;
  localparam logic [1:0] st_continue_burst = 2'd1;
  localparam logic [1:0] st_new_burst      = 2'd2;
  localparam logic [1:0] st_send_desc      = 2'd3;

  logic [f2c_pkg::ring_awidth:0]   pkt_size_r;
  logic [f2c_pkg::ring_awidth:0]   dsc_size_r;
  logic [f2c_pkg::ring_awidth-1:0] pkt_mask;
  logic [f2c_pkg::ring_awidth-1:0] dsc_mask;

  logic [1:0]         state;
  logic               running;
  f2c_pkg::pkt_meta_t meta_hold;
  logic               meta_hold_valid;
  f2c_pkg::pkt_meta_t cur_meta;
  logic [3:0]         burst_left;

  f2c_pkg::pkt_meta_t              sel;
  logic                            go;
  logic                            first_beat;
  logic                            skip_sel;
  logic                            beat_take;
  logic                            compl_take;
  logic                            desc_go;
  logic [3:0]                      beat_len;
  logic [3:0]                      left_after;
  logic [f2c_pkg::ring_awidth-1:0] next_tail;
  logic [1:0]                      beat_next;
  f2c_pkg::dsc_word_u              dsc_rx;
  f2c_pkg::dsc_word_u              dsc_cp;

  // Beats in the next burst, limited by packet, burst size and ring end
  function automatic logic [3:0] burst_len(
    input logic [6:0]                      remaining,
    input logic [f2c_pkg::ring_awidth-1:0] tail,
    input logic [f2c_pkg::ring_awidth:0]   ring_size
  );
    logic [7:0] len;
    logic [7:0] to_end;
    to_end = 8'(ring_size) - 8'(tail);
    len = 8'(remaining);
    if (len > 8'(f2c_pkg::max_burst)) begin
      len = 8'(f2c_pkg::max_burst);
    end
    if (len > to_end) begin
      len = to_end;
    end
    return len[3:0];
  endfunction

  // Ring configuration is static while traffic runs
  always_ff @(posedge clk) begin
    pkt_size_r <= pkt_ring_size;
    dsc_size_r <= dsc_ring_size;
    pkt_mask   <= f2c_pkg::ring_awidth'(pkt_size_r - 1'b1);
    dsc_mask   <= f2c_pkg::ring_awidth'(dsc_size_r - 1'b1);
  end

  assign go = running && !sw_reset && !mem_waitrequest;

  always_comb begin
    // A new packet reads its fields from the held metadata
    sel        = (state == st_idle) ? meta_hold : cur_meta;
    first_beat = (state != st_continue_burst);
    skip_sel   = (sel.pkt_base == '0) && (sel.dsc_base == '0);
    beat_len   = burst_len(sel.size, sel.pkt_tail, pkt_size_r);
    left_after = first_beat ? beat_len - 4'd1 : burst_left - 4'd1;
    next_tail  = (sel.pkt_tail + 1'b1) & pkt_mask;

    if (left_after != 4'd0) begin
      beat_next = st_continue_burst;
    end else if (sel.size > 7'd1) begin
      beat_next = st_new_burst;
    end else if (sel.needs_dsc && !skip_sel) begin
      beat_next = st_send_desc;
    end else begin
      beat_next = st_idle;
    end
  end

  // Completions go ahead of the next packet
  assign compl_ready = go && (state == st_idle);
  assign compl_take  = compl_valid && compl_ready;
  assign beat_ready  = go && ((state == st_continue_burst) || (state == st_new_burst) ||
                              ((state == st_idle) && !compl_valid && meta_hold_valid));
  assign beat_take   = beat_valid && beat_ready;
  assign desc_go     = go && (state == st_send_desc);
  assign meta_ready  = running && (!meta_hold_valid || (beat_take && (state == st_idle)));

  always_comb begin
    dsc_cp = '0;
    dsc_cp.compl_view.signal        = 1'b0;
    dsc_cp.compl_view.transfer_addr = compl_data.transfer_addr;
    dsc_cp.compl_view.length        = compl_data.length;

    dsc_rx = '0;
    dsc_rx.rx_view.signal   = 1'b1;
    dsc_rx.rx_view.tail     = 16'(cur_meta.pkt_tail);
    dsc_rx.rx_view.queue_id = cur_meta.queue_id;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running         <= 1'b0;
      state           <= st_idle;
      meta_hold_valid <= 1'b0;
      req_write       <= 1'b0;
    end else begin
      running <= 1'b1;
      if (meta_ready) begin
        meta_hold_valid <= meta_valid;
      end
      // Dropped and unconfigured packets still walk through their beats
      if (!mem_waitrequest) begin
        req_write <= (beat_take && !sel.drop && !skip_sel) || compl_take || desc_go;
      end
      if (sw_reset) begin
        state <= st_idle;
      end else if (beat_take) begin
        state <= beat_next;
      end else if (desc_go) begin
        state <= st_idle;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (meta_ready) begin
      meta_hold <= meta_data;
    end
    if (beat_take) begin
      cur_meta          <= sel;
      cur_meta.pkt_tail <= next_tail;
      cur_meta.size     <= sel.size - 7'd1;
      burst_left        <= left_after;
      req_writedata     <= beat_data.data;
      if (first_beat) begin
        req_address    <= sel.pkt_base +
                          f2c_pkg::addr_t'(sel.pkt_tail) * f2c_pkg::beat_bytes;
        req_burstcount <= beat_len;
      end
    end else if (compl_take) begin
      req_address    <= compl_data.dsc_addr;
      req_writedata  <= dsc_cp;
      req_burstcount <= 4'd1;
    end else if (desc_go) begin
      req_address    <= cur_meta.dsc_base +
                        f2c_pkg::addr_t'(cur_meta.dsc_tail & dsc_mask) * f2c_pkg::beat_bytes;
      req_writedata  <= dsc_rx;
      req_burstcount <= 4'd1;
    end
  end

endmodule

//--- source/bus_output_stage.sv
`timescale 1ns/10ps

module bus_output_stage (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           sw_reset,
  input  logic           req_write,
  input  f2c_pkg::addr_t req_address,
  input  logic [63:0]    req_writedata,
  input  logic [3:0]     req_burstcount,
  input  logic           mem_waitrequest,
  output f2c_pkg::addr_t mem_address,
  output logic           mem_write,
  output logic [63:0]    mem_writedata,
  output logic [3:0]     mem_burstcount,
  output logic [31:0]    stall_count
);

  logic [31:0] stall_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_write   <= 1'b0;
      stall_cnt   <= '0;
      stall_count <= '0;
    end else begin
      // Port holds its value until the slave accepts it
      if (!mem_waitrequest) begin
        mem_write <= req_write;
      end
      if (sw_reset) begin
        stall_cnt   <= '0;
        stall_count <= '0;
      end else if (mem_waitrequest) begin
        stall_cnt <= stall_cnt + 32'd1;
      end else begin
        stall_count <= stall_cnt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_waitrequest) begin
      mem_address    <= req_address;
      mem_writedata  <= req_writedata;
      mem_burstcount <= req_burstcount;
    end
  end

endmodule

//--- source/f2c_dma.sv
`timescale 1ns/10ps

module f2c_dma #(
  parameter int buf_depth   = 32,
  parameter int compl_depth = 16
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          sw_reset,

  input  f2c_pkg::beat_t                pkt_in_data,
  input  logic                          pkt_in_valid,
  output logic                          pkt_in_ready,
  output logic [$clog2(buf_depth):0]    pkt_occupancy,

  input  f2c_pkg::pkt_meta_t            meta_in_data,
  input  logic                          meta_in_valid,
  output logic                          meta_in_ready,
  output logic [$clog2(buf_depth):0]    meta_occupancy,

  input  f2c_pkg::tx_compl_t            compl_in_data,
  input  logic                          compl_in_valid,
  output logic                          compl_in_ready,
  output logic [$clog2(compl_depth):0]  compl_occupancy,

  input  logic [f2c_pkg::ring_awidth:0] pkt_ring_size,
  input  logic [f2c_pkg::ring_awidth:0] dsc_ring_size,

  output f2c_pkg::addr_t                mem_address,
  output logic                          mem_write,
  output logic [63:0]                   mem_writedata,
  output logic [3:0]                    mem_burstcount,
  input  logic                          mem_waitrequest,

  output logic [31:0]                   stall_count
);

  f2c_pkg::beat_t     pkt_data;
  logic               pkt_valid;
  logic               pkt_ready;
  f2c_pkg::pkt_meta_t meta_data;
  logic               meta_valid;
  logic               meta_ready;
  f2c_pkg::tx_compl_t compl_data;
  logic               compl_valid;
  logic               compl_ready;

  // Write request bundle between engine and port
  logic           req_write;
  f2c_pkg::addr_t req_address;
  logic [63:0]    req_writedata;
  logic [3:0]     req_burstcount;

  stream_fifo #(
    .width ($bits(f2c_pkg::beat_t)),
    .depth (buf_depth)
  ) u_pkt_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (pkt_in_data),
    .in_valid  (pkt_in_valid),
    .in_ready  (pkt_in_ready),
    .out_data  (pkt_data),
    .out_valid (pkt_valid),
    .out_ready (pkt_ready),
    .occupancy (pkt_occupancy)
  );

  stream_fifo #(
    .width ($bits(f2c_pkg::pkt_meta_t)),
    .depth (buf_depth)
  ) u_meta_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (meta_in_data),
    .in_valid  (meta_in_valid),
    .in_ready  (meta_in_ready),
    .out_data  (meta_data),
    .out_valid (meta_valid),
    .out_ready (meta_ready),
    .occupancy (meta_occupancy)
  );

  stream_fifo #(
    .width ($bits(f2c_pkg::tx_compl_t)),
    .depth (compl_depth)
  ) u_compl_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (compl_in_data),
    .in_valid  (compl_in_valid),
    .in_ready  (compl_in_ready),
    .out_data  (compl_data),
    .out_valid (compl_valid),
    .out_ready (compl_ready),
    .occupancy (compl_occupancy)
  );

  dma_write_engine u_engine (
    .clk             (clk),
    .rst_n           (rst_n),
    .sw_reset        (sw_reset),
    .pkt_ring_size   (pkt_ring_size),
    .dsc_ring_size   (dsc_ring_size),
    .beat_data       (pkt_data),
    .beat_valid      (pkt_valid),
    .beat_ready      (pkt_ready),
    .meta_data       (meta_data),
    .meta_valid      (meta_valid),
    .meta_ready      (meta_ready),
    .compl_data      (compl_data),
    .compl_valid     (compl_valid),
    .compl_ready     (compl_ready),
    .mem_waitrequest (mem_waitrequest),
    .req_write       (req_write),
    .req_address     (req_address),
    .req_writedata   (req_writedata),
    .req_burstcount  (req_burstcount)
  );

  bus_output_stage u_output (
    .clk             (clk),
    .rst_n           (rst_n),
    .sw_reset        (sw_reset),
    .req_write       (req_write),
    .req_address     (req_address),
    .req_writedata   (req_writedata),
    .req_burstcount  (req_burstcount),
    .mem_waitrequest (mem_waitrequest),
    .mem_address     (mem_address),
    .mem_write       (mem_write),
    .mem_writedata   (mem_writedata),
    .mem_burstcount  (mem_burstcount),
    .stall_count     (stall_count)
  );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held for 8 rising edges, released just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

//--- verif/f2c_dma_assertions.sv
`timescale 1ns/10ps

module f2c_dma_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic        mem_write,
  input logic        mem_waitrequest,
  input logic [31:0] mem_address,
  input logic [63:0] mem_writedata,
  input logic [3:0]  mem_burstcount
);

  // Beats still owed to the current burst, zero means the next beat starts one
  logic [3:0] beats_left;

  // Number of assertion failures so far
  int failures = 0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beats_left <= '0;
    end else if (mem_write && !mem_waitrequest) begin
      beats_left <= (beats_left == 4'd0) ? mem_burstcount - 4'd1 : beats_left - 4'd1;
    end
  end

  port_stable_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_write && mem_waitrequest) |=> ($stable(mem_write) && $stable(mem_address) &&
                                        $stable(mem_writedata) && $stable(mem_burstcount)))
    else begin
      $error("write port changed during waitrequest");
      failures++;
    end

  burstcount_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_write && beats_left == 4'd0) |-> (mem_burstcount >= 4'd1 && mem_burstcount <= 4'd8))
    else begin
      $error("burst count out of range on first beat");
      failures++;
    end

  write_low_after_reset: assert property (@(posedge clk) !rst_n |=> !mem_write)
    else begin
      $error("mem_write high after reset");
      failures++;
    end

endmodule

bind f2c_dma f2c_dma_assertions u_assertions (
  .clk             (clk),
  .rst_n           (rst_n),
  .mem_write       (mem_write),
  .mem_waitrequest (mem_waitrequest),
  .mem_address     (mem_address),
  .mem_writedata   (mem_writedata),
  .mem_burstcount  (mem_burstcount)
);

//--- verif/f2c_dma_tb.sv
`timescale 1ns/10ps

module f2c_dma_tb;

  logic clk;
  logic rst_n;
  logic sw_reset;
  f2c_pkg::beat_t     pkt_in_data;
  logic               pkt_in_valid;
  logic               pkt_in_ready;
  logic [5:0]         pkt_occupancy;
  f2c_pkg::pkt_meta_t meta_in_data;
  logic               meta_in_valid;
  logic               meta_in_ready;
  logic [5:0]         meta_occupancy;
  f2c_pkg::tx_compl_t compl_in_data;
  logic               compl_in_valid;
  logic               compl_in_ready;
  logic [4:0]         compl_occupancy;
  logic [6:0]         pkt_ring_size;
  logic [6:0]         dsc_ring_size;
  f2c_pkg::addr_t     mem_address;
  logic               mem_write;
  logic [63:0]        mem_writedata;
  logic [3:0]         mem_burstcount;
  logic               mem_waitrequest;
  logic [31:0]        stall_count;

  // Host memory model record
  f2c_pkg::addr_t wr_addr[$];
  logic [63:0]    wr_data[$];
  int             burst_sizes[$];
  int             beats_left;
  int             beat_idx;
  f2c_pkg::addr_t burst_addr;
  int             pend_stalls;
  logic           stall_en;
  logic           stall_hold;
  logic           random_now;
  logic           hold_now;
  logic [15:0]    lfsr;
  int errors;
  int checks;
  int test_errors;
  int tests_run;
  logic timed_out;

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  f2c_dma u_f2c_dma (.*);

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  always @(posedge clk) begin
    if (rst_n && mem_write && mem_waitrequest) begin
      pend_stalls++;
    end
    if (rst_n && mem_write && !mem_waitrequest) begin
      if (beats_left == 0) begin
        burst_addr = mem_address;
        beats_left = mem_burstcount;
        beat_idx = 0;
        burst_sizes.push_back(mem_burstcount);
      end
      wr_addr.push_back(burst_addr + f2c_pkg::addr_t'(8 * beat_idx));
      wr_data.push_back(mem_writedata);
      beat_idx++;
      beats_left--;
    end
  end

  // Stall controls are taken at the edge, waitrequest moves just after it
  always @(posedge clk) begin
    hold_now = stall_hold;
    random_now = stall_en;
    #1;
    if (hold_now) begin
      mem_waitrequest = 1'b1;
    end else if (random_now) begin
      lfsr = lfsr_step(lfsr);
      mem_waitrequest = lfsr[0];
    end else begin
      mem_waitrequest = 1'b0;
    end
  end

  function automatic logic [63:0] beat_value(input int tag, input int i);
    return {8'(tag), 24'h5a5a5a, 32'(i)};
  endfunction

  function automatic f2c_pkg::pkt_meta_t make_meta(input f2c_pkg::addr_t pbase, input int ptail,
      input f2c_pkg::addr_t dbase, input int dtail, input logic [7:0] qid, input int size,
      input logic drop, input logic needs);
    return '{pkt_base: pbase, pkt_tail: 6'(ptail), dsc_base: dbase, dsc_tail: 6'(dtail),
             queue_id: qid, size: 7'(size), drop: drop, needs_dsc: needs};
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic push_meta(input f2c_pkg::pkt_meta_t m);
    int waited;
    waited = 0;
    meta_in_data = m;
    meta_in_valid = 1'b1;
    while (!meta_in_ready && waited < 200) begin
      step();
      waited++;
    end
    if (!meta_in_ready) begin
      $display("Timed out waiting for the metadata input to accept");
      timed_out = 1'b1;
    end
    step();
    meta_in_valid = 1'b0;
  endtask

  task automatic push_beats(input int tag, input int n);
    int waited;
    for (int i = 0; i < n; i++) begin
      pkt_in_data = '{data: beat_value(tag, i), sop: (i == 0), eop: (i == n - 1)};
      pkt_in_valid = 1'b1;
      waited = 0;
      while (!pkt_in_ready && waited < 200) begin
        step();
        waited++;
      end
      if (!pkt_in_ready) begin
        $display("Timed out waiting for the packet input to accept");
        timed_out = 1'b1;
      end
      step();
    end
    pkt_in_valid = 1'b0;
  endtask

  task automatic wait_writes(input int n);
    int waited;
    waited = 0;
    while (wr_addr.size() < n && waited < 1000) begin
      step();
      waited++;
    end
    if (wr_addr.size() < n) begin
      $display("Timed out waiting for %0d memory writes, saw %0d", n, wr_addr.size());
      timed_out = 1'b1;
    end
  endtask

  // Inputs drained and the write port quiet for a few cycles
  task automatic wait_quiet();
    int waited;
    int quiet;
    waited = 0;
    quiet = 0;
    while (quiet < 4 && waited < 1000) begin
      step();
      waited++;
      if (pkt_occupancy == 0 && meta_occupancy == 0 && compl_occupancy == 0 && !mem_write) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    if (quiet < 4) begin
      $display("Timed out waiting for the DUT to go idle");
      timed_out = 1'b1;
    end
  endtask

  task automatic start_test();
    wr_addr.delete();
    wr_data.delete();
    burst_sizes.delete();
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d errors", name, test_errors);
    end
  endtask

  // Data beats expected from index first on, with the ring slot wrapping at 64
  task automatic check_packet(input int first, input f2c_pkg::addr_t base, input int tail,
      input int n, input int tag);
    int slot;
    for (int i = 0; i < n; i++) begin
      slot = (tail + i) % 64;
      check_value(64'(wr_addr[first + i]), 64'(base + 32'(8 * slot)), "data beat address");
      check_value(wr_data[first + i], beat_value(tag, i), "data beat value");
    end
  endtask

  task automatic check_rx_desc(input int idx, input f2c_pkg::addr_t exp_addr, input int tail,
      input logic [7:0] qid);
    check_value(64'(wr_addr[idx]), 64'(exp_addr), "descriptor address");
    check_value(wr_data[idx], {1'b1, 16'(tail), qid, 39'b0}, "receive descriptor");
  endtask

  task automatic test_single_burst();
    start_test();
    push_meta(make_meta(32'h1000_0000, 0, 32'h2000_0000, 5, 8'h3c, 3, 1'b0, 1'b1));
    push_beats(1, 3);
    wait_writes(4);
    wait_quiet();
    if (timed_out) return;
    check_value(wr_addr.size(), 4, "write count");
    check_value(burst_sizes[0], 3, "first burst length");
    check_packet(0, 32'h1000_0000, 0, 3, 1);
    check_rx_desc(3, 32'h2000_0000 + 32'd40, 3, 8'h3c);
    end_test("single burst");
  endtask

  task automatic run_split_burst();
    start_test();
    push_meta(make_meta(32'h1000_1000, 0, 32'h2000_0000, 0, 8'h11, 12, 1'b0, 1'b0));
    push_beats(2, 12);
    wait_writes(12);
    stall_en = 1'b0;
    wait_quiet();
    if (timed_out) return;
    check_value(wr_addr.size(), 12, "write count");
    check_value(burst_sizes.size(), 2, "burst count");
    check_value(burst_sizes[0], 8, "first burst length");
    check_value(burst_sizes[1], 4, "second burst length");
    check_packet(0, 32'h1000_1000, 0, 12, 2);
  endtask

  task automatic test_split_burst();
    run_split_burst();
    if (timed_out) return;
    end_test("split burst");
  endtask

  task automatic test_ring_wrap();
    start_test();
    push_meta(make_meta(32'h1000_2000, 61, 32'h2000_1000, 9, 8'h42, 6, 1'b0, 1'b1));
    push_beats(3, 6);
    wait_writes(7);
    wait_quiet();
    if (timed_out) return;
    check_value(wr_addr.size(), 7, "write count");
    check_value(burst_sizes[0], 3, "burst length before the ring end");
    check_value(burst_sizes[1], 3, "burst length after the wrap");
    check_packet(0, 32'h1000_2000, 61, 6, 3);
    check_rx_desc(6, 32'h2000_1000 + 32'd72, 3, 8'h42);
    end_test("ring wrap");
  endtask

  task automatic test_drop_and_skip();
    start_test();
    push_meta(make_meta(32'h1000_3000, 10, 32'h2000_2000, 2, 8'h77, 4, 1'b1, 1'b1));
    push_beats(4, 4);
    // Zero ring bases, consumed without any write
    push_meta(make_meta(32'h0, 0, 32'h0, 0, 8'h78, 2, 1'b0, 1'b1));
    push_beats(5, 2);
    wait_writes(1);
    wait_quiet();
    if (timed_out) return;
    check_value(wr_addr.size(), 1, "write count");
    check_rx_desc(0, 32'h2000_2000 + 32'd16, 14, 8'h77);
    end_test("drop and zero bases");
  endtask

  task automatic test_completion_first();
    start_test();
    // Engine frozen so that the completion and the packet wait side by side
    stall_hold = 1'b1;
    step();
    step();
    compl_in_data = '{dsc_addr: 32'h3000_0040, transfer_addr: 32'h4455_6600, length: 16'h05dc};
    compl_in_valid = 1'b1;
    if (!compl_in_ready) begin
      $display("Completion input not ready while empty");
      errors++;
      test_errors++;
    end
    step();
    compl_in_valid = 1'b0;
    push_meta(make_meta(32'h1000_4000, 0, 32'h2000_3000, 0, 8'h21, 2, 1'b0, 1'b0));
    push_beats(6, 2);
    step();
    step();
    // Metadata moves on into the held entry, beats and completion stay queued
    check_value(64'(compl_occupancy), 64'd1, "completion FIFO occupancy");
    check_value(64'(meta_occupancy), 64'd0, "metadata FIFO occupancy");
    check_value(64'(pkt_occupancy), 64'd2, "packet FIFO occupancy");
    stall_hold = 1'b0;
    wait_writes(3);
    wait_quiet();
    if (timed_out) return;
    check_value(wr_addr.size(), 3, "write count");
    check_value(burst_sizes[0], 1, "completion burst length");
    check_value(64'(wr_addr[0]), 64'h3000_0040, "completion address");
    check_value(wr_data[0], {1'b0, 32'h4455_6600, 16'h05dc, 15'b0}, "completion descriptor");
    check_packet(1, 32'h1000_4000, 0, 2, 6);
    end_test("completion priority");
  endtask

  task automatic test_stalls();
    pend_stalls = 0;
    stall_en = 1'b1;
    run_split_burst();
    if (timed_out) return;
    step();
    step();
    check_value(64'(stall_count >= pend_stalls), 64'd1, "stall count not below stalls seen");
    sw_reset = 1'b1;
    step();
    sw_reset = 1'b0;
    step();
    check_value(64'(stall_count), 64'd0, "stall count after software reset");
    end_test("random stalls");
  endtask

  initial begin
    int waited;
    sw_reset = 1'b0;
    pkt_in_data = '0;
    pkt_in_valid = 1'b0;
    meta_in_data = '0;
    meta_in_valid = 1'b0;
    compl_in_data = '0;
    compl_in_valid = 1'b0;
    pkt_ring_size = 7'd64;
    dsc_ring_size = 7'd64;
    mem_waitrequest = 1'b0;
    stall_en = 1'b0;
    stall_hold = 1'b0;
    lfsr = 16'd18;
    beats_left = 0;
    beat_idx = 0;
    pend_stalls = 0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    timed_out = 1'b0;
    waited = 0;
    while (rst_n !== 1'b1 && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timed out waiting for reset release");
      timed_out = 1'b1;
    end
    step();
    if (!timed_out) test_single_burst();
    if (!timed_out) test_split_burst();
    if (!timed_out) test_ring_wrap();
    if (!timed_out) test_drop_and_skip();
    if (!timed_out) test_completion_first();
    if (!timed_out) test_stalls();
    if (u_f2c_dma.u_assertions.failures != 0) begin
      $display("Write port assertions failed %0d times", u_f2c_dma.u_assertions.failures);
      errors += u_f2c_dma.u_assertions.failures;
    end
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- f2c_dma.f
source/f2c_pkg.sv
source/stream_fifo.sv
source/dma_write_engine.sv
source/bus_output_stage.sv
source/f2c_dma.sv
verif/tb_clock_gen.sv
verif/f2c_dma_assertions.sv
verif/f2c_dma_tb.sv
